/* Makefile */
# Verilator build and run for the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= if_stage_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qF -- '*** PASSED ***' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
source/if_pkg.sv
source/fetch_target_mux.sv
source/fetch_unit.sv
source/if_id_reg.sv
source/pc_seq_check.sv
source/if_stage.sv
sim/tb_clock.sv
sim/if_stage_assertions.sv
sim/if_stage_tb.sv

/* sim/if_stage_assertions.sv */
// memory handshake checks, bound into every fetch_unit instance
// sampled on the rising edge, disabled while reset is low

`timescale 1ns/1ps
`default_nettype none

module if_stage_assertions (
  input var logic          clk_i,
  input var logic          rst_ni,
  input var logic          req_i,
  input var logic          ack_i,
  input var if_pkg::addr_t addr_i
);

  int unsigned addr_errors = 0;
  int unsigned rise_errors = 0;
  int unsigned align_errors = 0;
  // failures of all three properties
  int unsigned error_count;

  assign error_count = addr_errors + rise_errors + align_errors;

  // phase 1, address held while req is up
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_i && $past(req_i)) |-> (addr_i == $past(addr_i)))
    else begin
      $error("memory address changed while req was high");
      addr_errors++;
    end

  // new req only after ack was seen low
  req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(req_i) |-> !$past(ack_i))
    else begin
      $error("req rose while ack was still high");
      rise_errors++;
    end

  word_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (addr_i[1:0] == 2'b00))
    else begin
      $error("fetch address is not word aligned");
      align_errors++;
    end

endmodule

bind fetch_unit if_stage_assertions u_protocol_checks (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (mem_req_o),
  .ack_i  (mem_ack_i),
  .addr_i (mem_addr_o)
);

`default_nettype wire

/* sim/if_stage_tb.sv */
// random test of the fetch stage against a reference pc model
// inputs change on the falling edge, outputs are checked there too
// memory returns addr ^ 32'hA5A5_5A5A, err on the last word of each 256 byte block

`timescale 1ns/1ps
`default_nettype none

module if_stage_tb;

  localparam int unsigned NUM_REDIRECTS = 60;

  logic clk;
  logic rst_n;
  logic req;
  logic pc_set;
  logic id_ready;
  logic valid_clear;
  if_pkg::pc_sel_e     pc_sel;
  if_pkg::exc_pc_sel_e exc_pc_sel;
  if_pkg::irq_vec_t    irq_vec;
  if_pkg::addr_t       boot_addr, branch_target, mtvec, mepc;
  // memory side
  logic mem_req, mem_ack, mem_err;
  if_pkg::addr_t  mem_addr;
  if_pkg::instr_t mem_rdata;
  // towards ID
  logic instr_valid, instr_new, fetch_err, mtvec_init, alert, busy;
  if_pkg::instr_t instr_rdata;
  if_pkg::addr_t  pc_id, pc_if;

  // reference state
  logic [31:0] rng_stim, rng_mem, exp_pc;
  logic        exp_valid;
  int unsigned since_set;
  // a boot redirect is driven this cycle
  logic        boot_set;
  // handshake in flight, from req rise until ack seen low
  logic        exp_busy;
  // ack as the DUT saw it at the last rising edge
  logic        ack_at_edge;

  tb_clock u_clock (.clk_o (clk));

  if_stage u_dut (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req), .boot_addr_i (boot_addr),
    .pc_set_i (pc_set), .pc_sel_i (pc_sel), .exc_pc_sel_i (exc_pc_sel),
    .irq_vec_i (irq_vec), .branch_target_i (branch_target), .csr_mtvec_i (mtvec),
    .csr_mepc_i (mepc), .id_ready_i (id_ready), .instr_valid_clear_i (valid_clear),
    .mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_ack_i (mem_ack),
    .mem_rdata_i (mem_rdata), .mem_err_i (mem_err),
    .instr_valid_id_o (instr_valid), .instr_new_id_o (instr_new),
    .instr_rdata_id_o (instr_rdata), .instr_fetch_err_o (fetch_err), .pc_id_o (pc_id),
    .pc_if_o (pc_if), .csr_mtvec_init_o (mtvec_init), .pc_mismatch_alert_o (alert),
    .if_busy_o (busy)
  );

  always @(posedge clk) begin
    ack_at_edge <= mem_ack;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_rand(output logic [31:0] value);
    rng_stim = lcg_next(rng_stim);
    value = rng_stim;
  endtask

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "fetch stage output did not match the model");
    end
  endtask

  // kind: 0 boot, 1 jump, 2 exception, 3 interrupt, 4 debug halt, 5 eret
  function automatic logic [31:0] expected_target(input int unsigned kind);
    case (kind)
      0:       return {boot_addr[31:8], 8'h80};
      1:       return {branch_target[31:2], 2'b00};
      2:       return {mtvec[31:8], 8'h00};
      // vectored, bit 7 zero, one word per line
      3:       return {mtvec[31:8], 1'b0, irq_vec, 2'b00};
      4:       return 32'h1A11_0800;
      default: return {mepc[31:2], 2'b00};
    endcase
  endfunction

  task automatic drive_redirect(input int unsigned kind);
    logic [31:0] a;
    logic [31:0] b;
    next_rand(a);
    next_rand(b);
    boot_addr = {a[31:16], b[31:16]};
    branch_target = {b[31:16], a[31:16]};
    next_rand(a);
    next_rand(b);
    mtvec = {a[31:16], b[31:16]};
    mepc = {b[31:16], a[31:16]};
    irq_vec = a[20:16];
    pc_set = 1'b1;
    boot_set = (kind == 0);
    case (kind)
      0: pc_sel = if_pkg::PC_BOOT;
      1: pc_sel = if_pkg::PC_JUMP;
      5: pc_sel = if_pkg::PC_ERET;
      default: pc_sel = if_pkg::PC_EXC;
    endcase
    if (kind == 2) exc_pc_sel = if_pkg::EXC_PC_EXC;
    if (kind == 3) exc_pc_sel = if_pkg::EXC_PC_IRQ;
    if (kind == 4) exc_pc_sel = if_pkg::EXC_PC_DBG;
    // first accepted word after this must be the target
    exp_pc = expected_target(kind);
  endtask

  // called before the inputs of this cycle are changed
  task automatic check_outputs(input logic started);
    check_equal(u_dut.u_fetch_unit.u_protocol_checks.error_count, 32'd0,
                "handshake assertion failures");
    check_equal(32'(alert), 32'd0, "pc mismatch alert");
    check_equal(32'(mtvec_init), 32'(boot_set), "mtvec init");
    if (!started) check_equal(32'(mem_req), 32'd0, "req before first redirect");
    exp_busy = mem_req | (exp_busy & ack_at_edge);
    check_equal(32'(busy), 32'(exp_busy), "busy flag");
    exp_valid = instr_new | (exp_valid & ~valid_clear);
    check_equal(32'(instr_valid), 32'(exp_valid), "instr valid flag");
    if (instr_new) begin
      check_equal(32'(id_ready & ~pc_set), 32'd1, "new instruction without an accept");
      check_equal(pc_id, exp_pc, "pc of new instruction");
      check_equal(instr_rdata, exp_pc ^ 32'hA5A5_5A5A, "instruction data");
      check_equal(32'(fetch_err), 32'(&exp_pc[7:2]), "fetch error flag");
      // IF moves on to the next word once the previous one is accepted
      check_equal(pc_if, exp_pc + 32'd4, "IF pc after accept");
      exp_pc = exp_pc + 32'd4;
      since_set++;
    end
  endtask

  //////////////////////////////////////////////////
  // memory model, four-phase with random delays
  //////////////////////////////////////////////////

  initial begin : memory_model
    mem_ack = 1'b0;
    mem_rdata = '0;
    mem_err = 1'b0;
    rng_mem = lcg_next(32'h937d_72ba ^ 32'h5555_5555);
    forever begin
      @(negedge clk);
      if (mem_req && !mem_ack) begin
        rng_mem = lcg_next(rng_mem);
        repeat (rng_mem[31:30]) @(negedge clk);
        mem_ack = 1'b1;
        mem_rdata = mem_addr ^ 32'hA5A5_5A5A;
        mem_err = &mem_addr[7:2];
        // phase 3, wait for req to drop
        do @(negedge clk); while (mem_req);
        rng_mem = lcg_next(rng_mem);
        repeat (rng_mem[29:28]) @(negedge clk);
        mem_ack = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus and checks
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] r;
    int unsigned cycle;
    int unsigned redirects;
    int unsigned gap;
    logic        started;
    rng_stim = 32'h937d_72ba;
    rst_n = 1'b0;
    req = 1'b0;
    pc_set = 1'b0;
    id_ready = 1'b0;
    valid_clear = 1'b0;
    pc_sel = if_pkg::PC_BOOT;
    exc_pc_sel = if_pkg::EXC_PC_EXC;
    irq_vec = '0;
    boot_addr = '0;
    branch_target = '0;
    mtvec = '0;
    mepc = '0;
    exp_pc = '0;
    exp_valid = 1'b0;
    exp_busy = 1'b0;
    boot_set = 1'b0;
    since_set = 0;
    cycle = 0;
    redirects = 0;
    gap = 0;
    started = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (!((redirects == NUM_REDIRECTS) && (since_set >= 6))) begin
      @(negedge clk);
      check_outputs(started);
      next_rand(r);
      // ID ready three cycles out of four
      id_ready = (r[31:30] != 2'd0);
      valid_clear = r[29];
      pc_set = 1'b0;
      boot_set = 1'b0;
      pc_sel = if_pkg::pc_sel_e'(r[28:27]);
      exc_pc_sel = (r[26:25] == 2'd3) ? if_pkg::EXC_PC_EXC : if_pkg::exc_pc_sel_e'(r[26:25]);
      if (cycle == 4) req = 1'b1;
      // boot first, later redirects cycle through all kinds
      if ((!started && cycle == 8) ||
          (started && redirects < NUM_REDIRECTS && since_set >= gap && r[24:22] == 3'd0)) begin
        drive_redirect(redirects % 6);
        redirects++;
        since_set = 0;
        gap = 32'(r[21:18]);
        started = 1'b1;
      end
      cycle++;
    end
    $display("*** PASSED ***");
    $finish;
  end

  // 400 cycles per redirect plus startup
  initial begin : watchdog
    repeat ((NUM_REDIRECTS + 2) * 400) @(posedge clk);
    $display("timeout: the fetch stage stopped delivering instructions");
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
// free running testbench clock, 100 ns period
// starts low, first rising edge at 50 ns

`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output var logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period of 50 ns
  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* source/fetch_target_mux.sv */
// redirect address selection, purely combinational
// the result is always word aligned, bits [1:0] are forced to zero
// unknown selector codes fall back to the boot target

`timescale 1ns/1ps
`default_nettype none

module fetch_target_mux (
  input  var if_pkg::pc_sel_e     pc_sel_i,
  input  var if_pkg::exc_pc_sel_e exc_pc_sel_i,
  input  var if_pkg::irq_vec_t    irq_vec_i,
  input  var if_pkg::addr_t       boot_addr_i,
  input  var if_pkg::addr_t       branch_target_i,
  input  var if_pkg::addr_t       csr_mtvec_i,
  input  var if_pkg::addr_t       csr_mepc_i,
  output var if_pkg::addr_t       target_o
);

  // boot entry inside the boot page
  if_pkg::addr_t boot_pc;
  // trap handler address
  if_pkg::addr_t exc_pc;
  // selected address before alignment
  if_pkg::addr_t sel_pc;

  assign boot_pc = {boot_addr_i[31:if_pkg::VEC_BASE_LSB], if_pkg::BOOT_OFFSET};

  //////////////////////////////////////////////////
  // exception vector
  //////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_sel_i)
      // base of the mtvec table
      if_pkg::EXC_PC_EXC: exc_pc = {csr_mtvec_i[31:if_pkg::VEC_BASE_LSB],
                                    {if_pkg::VEC_BASE_LSB{1'b0}}};
      // vectored mode, one word per interrupt line
      if_pkg::EXC_PC_IRQ: exc_pc = {csr_mtvec_i[31:if_pkg::VEC_BASE_LSB], 1'b0,
                                    irq_vec_i, 2'b00};
      if_pkg::EXC_PC_DBG: exc_pc = if_pkg::DM_HALT_ADDR;
      default:            exc_pc = {csr_mtvec_i[31:if_pkg::VEC_BASE_LSB],
                                    {if_pkg::VEC_BASE_LSB{1'b0}}};
    endcase
  end

  //////////////////////////////////////////////////
  // redirect target
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_sel_i)
      if_pkg::PC_BOOT: sel_pc = boot_pc;
      if_pkg::PC_JUMP: sel_pc = branch_target_i;
      if_pkg::PC_EXC:  sel_pc = exc_pc;
      // return from trap
      if_pkg::PC_ERET: sel_pc = csr_mepc_i;
      default:         sel_pc = boot_pc;
    endcase
  end

  // word alignment
  assign target_o = {sel_pc[31:2], 2'b00};

endmodule

`default_nettype wire

/* source/fetch_unit.sv */
// single word fetch over a four-phase req/ack handshake
// one buffered word, no prefetch; a redirect drops the word on offer
// a cancelled handshake still completes before the new target is requested

`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  var logic          clk_i,
  input  var logic          rst_ni,
  input  var logic          req_i,
  input  var logic          pc_set_i,
  input  var if_pkg::addr_t target_i,
  input  var logic          id_ready_i,
  output var logic          mem_req_o,
  output var if_pkg::addr_t mem_addr_o,
  input  var logic          mem_ack_i,
  input  var if_pkg::instr_t mem_rdata_i,
  input  var logic          mem_err_i,
  output var logic          fetch_valid_o,
  output var if_pkg::instr_t fetch_rdata_o,
  output var if_pkg::addr_t fetch_addr_o,
  output var logic          fetch_err_o,
  output var logic          busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT_ACK_LOW,
    FULL
  } fetch_state_e;

  fetch_state_e   state_q, state_d;
  // address of the word in flight or on offer
  if_pkg::addr_t  addr_q, addr_d;
  // fetch pc, remembers a redirect during a handshake
  if_pkg::addr_t  pc_q, pc_d;
  logic           pc_valid_q, pc_valid_d;
  // handshake in flight was cancelled by a redirect
  logic           discard_q, discard_d;
  if_pkg::instr_t rdata_q;
  logic           err_q;
  logic           capture;

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    addr_d     = addr_q;
    pc_d       = pc_q;
    discard_d  = discard_q;
    pc_valid_d = pc_valid_q | pc_set_i;
    capture    = 1'b0;
    if (pc_set_i) begin
      pc_d = target_i;
    end
    unique case (state_q)
      IDLE: begin
        if (pc_set_i) begin
          addr_d = target_i;
        end
        // nothing to fetch until a first pc is loaded
        if (req_i && (pc_set_i || pc_valid_q)) begin
          state_d = REQ;
        end
      end
      REQ: begin
        if (pc_set_i) begin
          discard_d = 1'b1;
        end
        if (mem_ack_i) begin
          capture = ~(discard_q | pc_set_i);
          state_d = WAIT_ACK_LOW;
        end
      end
      WAIT_ACK_LOW: begin
        if (pc_set_i) begin
          discard_d = 1'b1;
        end
        // phase 4 done, ack seen low
        if (!mem_ack_i) begin
          discard_d = 1'b0;
          if (discard_q || pc_set_i) begin
            // drop the word and go for the redirect target
            addr_d  = pc_d;
            state_d = req_i ? REQ : IDLE;
          end else begin
            state_d = FULL;
          end
        end
      end
      FULL: begin
        if (pc_set_i) begin
          addr_d  = target_i;
          state_d = req_i ? REQ : IDLE;
        end else if (id_ready_i) begin
          addr_d  = addr_q + if_pkg::INSTR_BYTES;
          pc_d    = addr_d;
          state_d = req_i ? REQ : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      addr_q     <= '0;
      pc_q       <= '0;
      pc_valid_q <= 1'b0;
      discard_q  <= 1'b0;
      rdata_q    <= '0;
      err_q      <= 1'b0;
    end else begin
      state_q    <= state_d;
      addr_q     <= addr_d;
      pc_q       <= pc_d;
      pc_valid_q <= pc_valid_d;
      discard_q  <= discard_d;
      if (capture) begin
        rdata_q <= mem_rdata_i;
        err_q   <= mem_err_i;
      end
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign mem_req_o     = (state_q == REQ);
  assign mem_addr_o    = addr_q;
  // a redirect squashes the word on offer
  assign fetch_valid_o = (state_q == FULL) & ~pc_set_i;
  assign fetch_rdata_o = rdata_q;
  assign fetch_addr_o  = addr_q;
  assign fetch_err_o   = err_q;
  assign busy_o        = (state_q == REQ) | (state_q == WAIT_ACK_LOW);

endmodule

`default_nettype wire

/* source/if_id_reg.sv */
// IF-ID pipeline registers with valid and new flags
// valid is held until cleared, new is a one cycle pulse per accepted word

`timescale 1ns/1ps
`default_nettype none

module if_id_reg (
  input  var logic           clk_i,
  input  var logic           rst_ni,
  input  var logic           fetch_valid_i,
  input  var if_pkg::instr_t fetch_rdata_i,
  input  var if_pkg::addr_t  fetch_addr_i,
  input  var logic           fetch_err_i,
  input  var logic           id_ready_i,
  input  var logic           instr_valid_clear_i,
  output var logic           accept_o,
  output var logic           instr_valid_id_o,
  output var logic           instr_new_id_o,
  output var if_pkg::instr_t instr_rdata_id_o,
  output var logic           instr_fetch_err_o,
  output var if_pkg::addr_t  pc_id_o
);

  logic accept;

  // word moves into ID when offered and ID is ready
  assign accept   = fetch_valid_i & id_ready_i;
  assign accept_o = accept;

  //////////////////////////////////////////////////
  // flags and payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o  <= 1'b0;
      instr_new_id_o    <= 1'b0;
      instr_rdata_id_o  <= '0;
      instr_fetch_err_o <= 1'b0;
      pc_id_o           <= '0;
    end else begin
      // a new word wins over a clear in the same cycle
      instr_valid_id_o <= accept | (instr_valid_id_o & ~instr_valid_clear_i);
      instr_new_id_o   <= accept;
      if (accept) begin
        instr_rdata_id_o  <= fetch_rdata_i;
        instr_fetch_err_o <= fetch_err_i;
        pc_id_o           <= fetch_addr_i;
      end
    end
  end

endmodule

`default_nettype wire

/* source/if_pkg.sv */
// shared types and fixed addresses of the instruction fetch stage
// instructions are 32 bit and word aligned, no compressed support
// boot and mtvec bases are assumed aligned to 256 bytes

`default_nettype none

package if_pkg;

  //////////////////////////////////////////////////
  // data types
  //////////////////////////////////////////////////

  // byte address
  typedef logic [31:0] addr_t;
  // one instruction word
  typedef logic [31:0] instr_t;
  // vectored interrupt index
  typedef logic [4:0]  irq_vec_t;

  // redirect source selected by the core
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // kind of exception target
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBG
  } exc_pc_sel_e;

  //////////////////////////////////////////////////
  // fixed addresses and constants
  //////////////////////////////////////////////////

  // debug module halt entry
  localparam addr_t       DM_HALT_ADDR = 32'h1A11_0800;
  // boot entry inside the boot page
  localparam logic [7:0]  BOOT_OFFSET  = 8'h80;
  // low bits ignored in boot and mtvec bases
  localparam int unsigned VEC_BASE_LSB = 8;
  // sequential pc step
  localparam addr_t       INSTR_BYTES  = 32'd4;

endpackage

`default_nettype wire

/* source/if_stage.sv */
// instruction fetch stage top, target mux -> fetch unit -> IF-ID register
// the pc sequence check sits beside the IF-ID register
// boot_addr_i and csr_mtvec_i low bytes are ignored

`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  var logic                clk_i,
  input  var logic                rst_ni,
  input  var logic                req_i,
  input  var if_pkg::addr_t       boot_addr_i,
  input  var logic                pc_set_i,
  input  var if_pkg::pc_sel_e     pc_sel_i,
  input  var if_pkg::exc_pc_sel_e exc_pc_sel_i,
  input  var if_pkg::irq_vec_t    irq_vec_i,
  input  var if_pkg::addr_t       branch_target_i,
  input  var if_pkg::addr_t       csr_mtvec_i,
  input  var if_pkg::addr_t       csr_mepc_i,
  input  var logic                id_ready_i,
  input  var logic                instr_valid_clear_i,
  // instruction memory, four-phase req/ack
  output var logic                mem_req_o,
  output var if_pkg::addr_t       mem_addr_o,
  input  var logic                mem_ack_i,
  input  var if_pkg::instr_t      mem_rdata_i,
  input  var logic                mem_err_i,
  // towards ID
  output var logic                instr_valid_id_o,
  output var logic                instr_new_id_o,
  output var if_pkg::instr_t      instr_rdata_id_o,
  output var logic                instr_fetch_err_o,
  output var if_pkg::addr_t       pc_id_o,
  output var if_pkg::addr_t       pc_if_o,
  output var logic                csr_mtvec_init_o,
  output var logic                pc_mismatch_alert_o,
  output var logic                if_busy_o
);

  if_pkg::addr_t  target;
  logic           fetch_valid;
  if_pkg::instr_t fetch_rdata;
  if_pkg::addr_t  fetch_addr;
  logic           fetch_err;
  logic           accept;

  fetch_target_mux u_target_mux (
    .pc_sel_i        (pc_sel_i),
    .exc_pc_sel_i    (exc_pc_sel_i),
    .irq_vec_i       (irq_vec_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .csr_mepc_i      (csr_mepc_i),
    .target_o        (target)
  );

  // ready comes from the IF-ID acceptance
  fetch_unit u_fetch_unit (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i),
    .pc_set_i (pc_set_i), .target_i (target), .id_ready_i (accept),
    .mem_req_o (mem_req_o), .mem_addr_o (mem_addr_o), .mem_ack_i (mem_ack_i),
    .mem_rdata_i (mem_rdata_i), .mem_err_i (mem_err_i),
    .fetch_valid_o (fetch_valid), .fetch_rdata_o (fetch_rdata),
    .fetch_addr_o (fetch_addr), .fetch_err_o (fetch_err), .busy_o (if_busy_o)
  );

  if_id_reg u_if_id_reg (
    .clk_i (clk_i), .rst_ni (rst_ni), .fetch_valid_i (fetch_valid),
    .fetch_rdata_i (fetch_rdata), .fetch_addr_i (fetch_addr), .fetch_err_i (fetch_err),
    .id_ready_i (id_ready_i), .instr_valid_clear_i (instr_valid_clear_i),
    .accept_o (accept), .instr_valid_id_o (instr_valid_id_o),
    .instr_new_id_o (instr_new_id_o), .instr_rdata_id_o (instr_rdata_id_o),
    .instr_fetch_err_o (instr_fetch_err_o), .pc_id_o (pc_id_o)
  );

  pc_seq_check u_pc_seq_check (
    .clk_i (clk_i), .rst_ni (rst_ni), .accept_i (accept), .pc_set_i (pc_set_i),
    .fetch_err_i (fetch_err), .pc_if_i (fetch_addr), .pc_id_i (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  assign pc_if_o = fetch_addr;
  // mtvec gets its reset value on boot
  assign csr_mtvec_init_o = pc_set_i & (pc_sel_i == if_pkg::PC_BOOT);

endmodule

`default_nettype wire

/* source/pc_seq_check.sv */
// control flow check, sequential pcs must step by one word
// the check pauses after any redirect or fetch error until the next accept

`timescale 1ns/1ps
`default_nettype none

module pc_seq_check (
  input  var logic          clk_i,
  input  var logic          rst_ni,
  input  var logic          accept_i,
  input  var logic          pc_set_i,
  input  var logic          fetch_err_i,
  input  var if_pkg::addr_t pc_if_i,
  input  var if_pkg::addr_t pc_id_i,
  output var logic          pc_mismatch_alert_o
);

  // previous instruction was sequential
  logic          prev_seq_q;
  // expected IF pc
  if_pkg::addr_t pc_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prev_seq_q <= 1'b0;
    end else begin
      prev_seq_q <= (prev_seq_q | accept_i) & ~pc_set_i & ~fetch_err_i;
    end
  end

  assign pc_next = pc_id_i + if_pkg::INSTR_BYTES;

  // combinational from the registered state
  assign pc_mismatch_alert_o = prev_seq_q & (pc_if_i != pc_next);

endmodule

`default_nettype wire
